//--- hdl/l2d_pkg.sv
// Set index cut to 4 bits for simulation; check bits are carried as opaque data, never generated
`default_nettype none

package l2d_pkg;

   // Word and line geometry
   localparam int WORD_W       = 39;                     // 32 data + 7 check
   localparam int WORDS_PER_SB = 4;
   localparam int NUM_SB       = 4;
   localparam int SB_W         = WORD_W * WORDS_PER_SB;  // 156
   localparam int LINE_W       = SB_W * NUM_SB;          // 624

   // Array organisation
   localparam int NUM_WAYS     = 12;                     // One-hot way select
   localparam int WAY_W        = $clog2(NUM_WAYS);
   localparam int SET_W        = 4;
   localparam int NUM_SETS     = 1 << SET_W;

   localparam int ST_W         = 2 * WORD_W;             // Store doubleword, 78
   localparam int RD_LAT_SB    = 2;                      // Subbank c3 to c5

   // Word 0 in the low bits
   typedef logic [WORDS_PER_SB-1:0][WORD_W-1:0] l2d_subline_t;

   // Subbank 0 in the low bits
   typedef l2d_subline_t [NUM_SB-1:0] l2d_line_t;

   // Request from the tag side at c2
   typedef struct packed {
      logic [NUM_WAYS-1:0]            way_sel;     // Zero means no access
      logic                           rd_wr;       // 1 is a read
      logic [SET_W-1:0]               set;
      logic [NUM_SB-1:0]              col_offset;  // One bit per subbank
      logic [NUM_SB*WORDS_PER_SB-1:0] word_en;     // Four per subbank
      logic [ST_W-1:0]                stdecc;
      logic                           fill;        // Full line write from wr_line
      l2d_line_t                      wr_line;
   } l2d_req_t;

   // Controls for one subbank at c3
   typedef struct packed {
      logic                    en;
      logic                    wr_en;
      logic [SET_W-1:0]        set;
      logic [WAY_W-1:0]        way;
      logic [WORDS_PER_SB-1:0] word_en;
      l2d_subline_t            wdata;
   } l2d_sb_ctl_t;

endpackage

`default_nettype wire

//--- hdl/l2d_req_stage.sv
// Way select must be zero or one-hot; a second set bit would merge way indices
`timescale 1ns/100ps
`default_nettype none

module l2d_req_stage import l2d_pkg::*; (
   input  wire                       rclk,
   input  wire                       rst_n,
   input  wire l2d_req_t             req,
   output l2d_sb_ctl_t [NUM_SB-1:0]  sb_ctl,
   output logic                      rd_c3,
   output logic [NUM_SB-1:0]         col_c3
);

   l2d_req_t         req_c3;     // Payload copy of the c2 request
   logic             vld_c3;     // Some way selected
   logic [WAY_W-1:0] way_c3;
   l2d_line_t        wline_c3;   // Write data per word

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         vld_c3 <= 1'b0;
      end else begin
         vld_c3 <= |req.way_sel;
      end
   end

   always_ff @(posedge rclk) begin
      req_c3 <= req;
   end

   // One-hot to index, OR of the set positions
   always_comb begin
      way_c3 = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (req_c3.way_sel[w]) begin
            way_c3 = way_c3 | WAY_W'(w);
         end
      end
   end

   // Fill takes the line as is, a store replicates the doubleword
   always_comb begin
      for (int s = 0; s < NUM_SB; s++) begin
         for (int i = 0; i < WORDS_PER_SB; i++) begin
            if (req_c3.fill) begin
               wline_c3[s][i] = req_c3.wr_line[s][i];
            end else if (i % 2 == 0) begin
               // Subbank size is even so local parity matches line parity
               wline_c3[s][i] = req_c3.stdecc[ST_W-1 -: WORD_W];
            end else begin
               wline_c3[s][i] = req_c3.stdecc[WORD_W-1:0];
            end
         end
      end
   end

   always_comb begin
      for (int s = 0; s < NUM_SB; s++) begin
         sb_ctl[s].en      = vld_c3 & req_c3.col_offset[s];
         sb_ctl[s].wr_en   = vld_c3 & req_c3.col_offset[s] & ~req_c3.rd_wr;
         sb_ctl[s].set     = req_c3.set;
         sb_ctl[s].way     = way_c3;
         sb_ctl[s].word_en = req_c3.word_en[s*WORDS_PER_SB +: WORDS_PER_SB];
         sb_ctl[s].wdata   = wline_c3[s];
      end
   end

   assign rd_c3  = vld_c3 & req_c3.rd_wr;  // Read in flight for the read stage
   assign col_c3 = req_c3.col_offset;

endmodule

`default_nettype wire

//--- hdl/l2d_subbank.sv
// Array contents are not reset; a read of an unwritten entry returns X until it is written
`timescale 1ns/100ps
`default_nettype none

module l2d_subbank import l2d_pkg::*; (
   input  wire              rclk,
   input  wire l2d_sb_ctl_t ctl,     // c3
   output l2d_subline_t     rdata    // c5
);

   // Sets by ways, one subline per entry
   l2d_subline_t mem [NUM_SETS][NUM_WAYS];

   // Stage 0 is the array output register, last stage drives rdata
   l2d_subline_t rd_pipe [RD_LAT_SB];

   logic         wr_en;
   logic         rd_en;

   assign wr_en = ctl.en & ctl.wr_en;
   assign rd_en = ctl.en & ~ctl.wr_en;

   // Word-enabled write
   always_ff @(posedge rclk) begin
      if (wr_en) begin
         for (int i = 0; i < WORDS_PER_SB; i++) begin
            if (ctl.word_en[i]) begin
               mem[ctl.set][ctl.way][i] <= ctl.wdata[i];
            end
         end
      end
   end

   // Array register only loads on a read, holds otherwise
   always_ff @(posedge rclk) begin
      if (rd_en) begin
         rd_pipe[0] <= mem[ctl.set][ctl.way];
      end
   end

   // Output register(s) behind the array
   always_ff @(posedge rclk) begin
      for (int p = 1; p < RD_LAT_SB; p++) begin
         rd_pipe[p] <= rd_pipe[p-1];
      end
   end

   assign rdata = rd_pipe[RD_LAT_SB-1];

endmodule

`default_nettype wire

//--- hdl/l2d_read_stage.sv
// fb_hit is only honoured for reads; fb_line must be stable in the c4 cycle of that read
`timescale 1ns/100ps
`default_nettype none

module l2d_read_stage import l2d_pkg::*; (
   input  wire                        rclk,
   input  wire                        rst_n,
   input  wire                        rd_c3,
   input  wire [NUM_SB-1:0]           col_c3,
   input  wire                        fb_hit,     // c3
   input  wire l2d_line_t             fb_line,    // c4
   input  wire l2d_subline_t [NUM_SB-1:0] sb_rdata,  // c5
   output l2d_subline_t               tag_data,   // c6
   output l2d_line_t                  line_data   // c7
);

   // Index 0 is c4, top index is c5
   logic [RD_LAT_SB-1:0]             rd_pipe;
   logic [RD_LAT_SB-1:0]             fb_pipe;
   logic [RD_LAT_SB-1:0][NUM_SB-1:0] col_pipe;

   logic              rd_c5;
   logic              fb_c5;
   logic [NUM_SB-1:0] col_c5;
   logic              rd_c6;
   l2d_line_t         fb_line_c5;
   l2d_line_t         sel_line_c5;
   l2d_line_t         mask_line_c5;
   l2d_subline_t      tag_c5;
   l2d_line_t         line_c6;
   logic [LINE_W-1:0] line_mask;

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         rd_pipe <= '0;
         fb_pipe <= '0;
         rd_c6   <= 1'b0;
      end else begin
         rd_pipe <= {rd_pipe[RD_LAT_SB-2:0], rd_c3};
         fb_pipe <= {fb_pipe[RD_LAT_SB-2:0], fb_hit};
         rd_c6   <= rd_c5;
      end
   end

   always_ff @(posedge rclk) begin
      col_pipe   <= {col_pipe[RD_LAT_SB-2:0], col_c3};
      fb_line_c5 <= fb_line;
   end

   assign rd_c5  = rd_pipe[RD_LAT_SB-1];
   assign fb_c5  = fb_pipe[RD_LAT_SB-1];
   assign col_c5 = col_pipe[RD_LAT_SB-1];

   // Whole subbank slices kept or cleared by column
   always_comb begin
      for (int s = 0; s < NUM_SB; s++) begin
         line_mask[s*SB_W +: SB_W] = {SB_W{col_c5[s]}};
      end
   end

   assign sel_line_c5  = fb_c5 ? fb_line_c5 : sb_rdata;  // Fill-buffer bypass
   assign mask_line_c5 = sel_line_c5 & line_mask;

   // Unselected slices are zero so the OR picks the read one
   always_comb begin
      tag_c5 = '0;
      for (int s = 0; s < NUM_SB; s++) begin
         tag_c5 = tag_c5 | mask_line_c5[s];
      end
   end

   always_ff @(posedge rclk) begin
      tag_data  <= rd_c5 ? tag_c5 : '0;
      line_c6   <= mask_line_c5;
      line_data <= rd_c6 ? line_c6 : '0;
   end

endmodule

`default_nettype wire

//--- hdl/l2d_bank.sv
// No back-pressure; the tag side must send legal requests, one-hot way select and a column per read
`timescale 1ns/100ps
`default_nettype none

module l2d_bank import l2d_pkg::*; (
   input  wire                rclk,
   input  wire                rst_n,
   input  wire l2d_req_t      req,        // c2
   input  wire                fb_hit,     // c3
   input  wire l2d_line_t     fb_line,    // c4
   output l2d_subline_t       tag_data,   // c6
   output l2d_line_t          line_data   // c7
);

   // Request stage to subbanks, c3
   l2d_sb_ctl_t  [NUM_SB-1:0] sb_ctl;

   // Subbanks to read stage, c5
   l2d_subline_t [NUM_SB-1:0] sb_rdata;

   // Read tracking handed to the read stage at c3
   logic                      rd_c3;
   logic [NUM_SB-1:0]         col_c3;

   l2d_req_stage req_stage (
      .rclk   (rclk),
      .rst_n  (rst_n),
      .req    (req),
      .sb_ctl (sb_ctl),
      .rd_c3  (rd_c3),
      .col_c3 (col_c3)
   );

   // One subbank per 156-bit slice of the line
   for (genvar s = 0; s < NUM_SB; s++) begin : g_subbank
      l2d_subbank subbank (
         .rclk  (rclk),
         .ctl   (sb_ctl[s]),
         .rdata (sb_rdata[s])
      );
   end

   l2d_read_stage read_stage (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .rd_c3     (rd_c3),
      .col_c3    (col_c3),
      .fb_hit    (fb_hit),
      .fb_line   (fb_line),
      .sb_rdata  (sb_rdata),
      .tag_data  (tag_data),
      .line_data (line_data)
   );

endmodule

`default_nettype wire

//--- dv/l2d_bank_checker.sv
// Covers only the request-side rules at the top-level ports; data paths are compared elsewhere
`timescale 1ns/100ps
`default_nettype none

module l2d_bank_checker import l2d_pkg::*; (
   input wire           rclk,
   input wire           rst_n,
   input wire l2d_req_t req,
   input wire           fb_hit
);

   int   fail_count = 0;   // Fired assertions so far
   logic rd_req;

   assign rd_req = (|req.way_sel) & req.rd_wr;

   // At most one way per request
   way_onehot: assert property (@(posedge rclk) disable iff (!rst_n)
      $onehot0(req.way_sel))
      else begin
         $error("way_sel has more than one bit set");
         fail_count = fail_count + 1;
      end

   read_has_column: assert property (@(posedge rclk) disable iff (!rst_n)
      rd_req |-> (|req.col_offset))
      else begin
         $error("read request without any col_offset bit");
         fail_count = fail_count + 1;
      end

   // Bypass hit belongs to the read taken one edge earlier
   fb_hit_after_read: assert property (@(posedge rclk) disable iff (!rst_n)
      fb_hit |-> $past(rd_req))
      else begin
         $error("fb_hit without a read request in the previous cycle");
         fail_count = fail_count + 1;
      end

endmodule

`default_nettype wire

//--- dv/l2d_bank_tests.svh
// Included inside the testbench module and uses its model, LFSR and drive tasks directly
`ifndef L2D_BANK_TESTS_SVH
`define L2D_BANK_TESTS_SVH

// Outputs are zero from the first cycle after reset and stay there with no traffic
task automatic reset_idle_check();
   check_en = 1'b1;
   for (int i = 0; i < 6; i++) begin
      step_cycle();
   end
endtask

task automatic store_then_tag_read();
   logic [1:0] pick;
   for (int n = 0; n < 4; n++) begin
      loc_set[n] = SET_W'(rand_bits(SET_W));
      loc_way[n] = rand_way();
      fill_line(loc_set[n], loc_way[n], l2d_line_t'(rand_bits(LINE_W)));  // Defined base
   end
   for (int n = 0; n < 10; n++) begin
      pick = 2'(rand_bits(2));
      store_dword(loc_set[pick], loc_way[pick], NUM_SB'(rand_bits(NUM_SB)),
                  WEN_W'(rand_bits(WEN_W)), ST_W'(rand_bits(ST_W)));
   end
   // One subbank per read
   for (int n = 0; n < 4; n++) begin
      for (int s = 0; s < NUM_SB; s++) begin
         send_read(loc_set[n], loc_way[n], NUM_SB'(1) << s, 1'b0, '0);
      end
   end
   wait_drain();
endtask

task automatic fill_then_evict();
   logic [SET_W-1:0] set;
   int               way;
   for (int n = 0; n < 3; n++) begin
      set = SET_W'(rand_bits(SET_W));
      way = rand_way();
      fill_line(set, way, l2d_line_t'(rand_bits(LINE_W)));
      send_read(set, way, '1, 1'b0, '0);
   end
   send_read(set, way, NUM_SB'(5), 1'b0, '0);  // Subbanks 1 and 3 zeroed
   wait_drain();
endtask

task automatic bypass_read();
   logic [SET_W-1:0] set;
   int               way;
   set = SET_W'(rand_bits(SET_W));
   way = rand_way();
   fill_line(set, way, l2d_line_t'(rand_bits(LINE_W)));
   send_read(set, way, NUM_SB'(1) << 2, 1'b1, l2d_line_t'(rand_bits(LINE_W)));
   send_read(set, way, '1, 1'b1, l2d_line_t'(rand_bits(LINE_W)));
   send_read(set, way, '1, 1'b0, '0);  // Array data again
   wait_drain();
endtask

// Back-to-back traffic over two earlier locations
task automatic pipelined_reads();
   int a;
   int b;
   a = 0;
   b = 1;
   store_dword(loc_set[a], loc_way[a], '1, WEN_W'(rand_bits(WEN_W)), ST_W'(rand_bits(ST_W)));
   for (int s = 0; s < NUM_SB; s++) begin
      if (s % 2 == 0) begin
         send_read(loc_set[a], loc_way[a], NUM_SB'(1) << s, 1'b0, '0);
      end else begin
         send_read(loc_set[b], loc_way[b], NUM_SB'(1) << s, 1'b0, '0);
      end
   end
   store_dword(loc_set[b], loc_way[b], '1, WEN_W'(rand_bits(WEN_W)), ST_W'(rand_bits(ST_W)));
   for (int s = 0; s < NUM_SB; s++) begin
      if (s % 2 == 0) begin
         send_read(loc_set[b], loc_way[b], NUM_SB'(1) << s, 1'b0, '0);
      end else begin
         send_read(loc_set[a], loc_way[a], NUM_SB'(1) << s, 1'b0, '0);
      end
   end
   wait_drain();
endtask

`endif

//--- dv/l2d_bank_tb.sv
// Latencies are fixed, so results are checked on cycle counts; reads only touch written entries
`timescale 1ns/100ps
`default_nettype none

module l2d_bank_tb import l2d_pkg::*; ();

   localparam logic [31:0] LFSR_SEED  = 32'h125e;
   localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;  // x^32+x^22+x^2+x+1
   localparam int          TAG_LAT    = 4;              // Drive cycle to tag_data check
   localparam int          LINE_LAT   = 5;
   localparam int          WAIT_LIMIT = 20;
   localparam int          WEN_W      = NUM_SB * WORDS_PER_SB;

   logic             rclk;
   logic             rst_n;
   l2d_req_t         req;
   logic             fb_hit;
   l2d_line_t        fb_line;
   l2d_subline_t     tag_data;
   l2d_line_t        line_data;

   logic [31:0]      lfsr_state;
   int unsigned      cyc;
   bit               check_en;       // Outputs compared every cycle once set

   l2d_line_t        model [int];    // Keyed by set and way
   l2d_subline_t     exp_tag [int unsigned];
   l2d_line_t        exp_line [int unsigned];
   bit               fb_hit_sched [int unsigned];
   l2d_line_t        fb_line_sched [int unsigned];
   logic [SET_W-1:0] loc_set [4];
   int               loc_way [4];

   l2d_bank DUT (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .req       (req),
      .fb_hit    (fb_hit),
      .fb_line   (fb_line),
      .tag_data  (tag_data),
      .line_data (line_data)
   );

   bind l2d_bank l2d_bank_checker bank_checker (
      .rclk   (rclk),
      .rst_n  (rst_n),
      .req    (req),
      .fb_hit (fb_hit)
   );

   initial rclk = 1'b0;
   always #4 rclk = ~rclk;

   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   function automatic logic next_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
      return b;
   endfunction

   // Low n bits random, rest zero
   function automatic logic [LINE_W-1:0] rand_bits(int n);
      logic [LINE_W-1:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = next_bit();
      end
      return v;
   endfunction

   function automatic int rand_way();
      return int'(rand_bits(WAY_W)) % NUM_WAYS;
   endfunction

   function automatic int loc_key(logic [SET_W-1:0] set, int way);
      return int'(set) * NUM_WAYS + way;
   endfunction

   task automatic halt_run();
      $display("Simulation failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_mismatch(string msg);
      $display("mismatch at %0t ns: %s", $time, msg);
      halt_run();
   endtask

   task automatic report_failure(string msg);
      $display("error at %0t ns: %s", $time, msg);
      halt_run();
   endtask

   // One clock: compare outputs, then drive the scheduled fill-buffer inputs
   task automatic step_cycle();
      l2d_subline_t exp_t;
      l2d_line_t    exp_l;
      @(posedge rclk);
      cyc++;
      #1;
      if (DUT.bank_checker.fail_count != 0) begin
         report_failure("a request rule assertion on the DUT ports fired");
      end
      if (check_en) begin
         exp_t = '0;                          // Zero when no read lands here
         exp_l = '0;
         if (exp_tag.exists(cyc)) begin
            exp_t = exp_tag[cyc];
            exp_tag.delete(cyc);
         end
         if (exp_line.exists(cyc)) begin
            exp_l = exp_line[cyc];
            exp_line.delete(cyc);
         end
         assert (tag_data === exp_t)
            else report_mismatch($sformatf("tag_data at cycle %0d is %h, expected %h",
                                           cyc, tag_data, exp_t));
         assert (line_data === exp_l)
            else report_mismatch($sformatf("line_data at cycle %0d differs from the model",
                                           cyc));
      end
      fb_hit = 1'b0;
      if (fb_hit_sched.exists(cyc)) begin
         fb_hit = fb_hit_sched[cyc];
         fb_hit_sched.delete(cyc);
      end
      fb_line = '1;                           // Decoy outside the c4 cycle of a bypass
      if (fb_line_sched.exists(cyc)) begin
         fb_line = fb_line_sched[cyc];
         fb_line_sched.delete(cyc);
      end
      req = '0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (n < WAIT_LIMIT && (exp_tag.num() != 0 || exp_line.num() != 0)) begin
         step_cycle();
         n++;
      end
      if (exp_tag.num() != 0 || exp_line.num() != 0) begin
         report_failure("expected read results were still pending at the timeout");
      end
   endtask

   // Write rule applied word by word
   function automatic void model_write(l2d_req_t r, int way);
      l2d_line_t cur;
      int        key;
      int        w;
      key = loc_key(r.set, way);
      cur = 'x;
      if (model.exists(key)) begin
         cur = model[key];
      end
      for (int s = 0; s < NUM_SB; s++) begin
         for (int i = 0; i < WORDS_PER_SB; i++) begin
            w = s * WORDS_PER_SB + i;
            if (r.word_en[w] && r.col_offset[s]) begin
               if (r.fill) begin
                  cur[s][i] = r.wr_line[s][i];
               end else if (w % 2 == 0) begin
                  cur[s][i] = r.stdecc[ST_W-1:WORD_W];
               end else begin
                  cur[s][i] = r.stdecc[WORD_W-1:0];
               end
            end
         end
      end
      model[key] = cur;
   endfunction

   task automatic store_dword(logic [SET_W-1:0] set, int way, logic [NUM_SB-1:0] col,
                              logic [WEN_W-1:0] wen, logic [ST_W-1:0] dword);
      l2d_req_t r;
      r = '0;
      r.way_sel    = NUM_WAYS'(1) << way;
      r.set        = set;
      r.col_offset = col;
      r.word_en    = wen;
      r.stdecc     = dword;
      r.wr_line    = '1;      // Must be ignored without fill
      model_write(r, way);
      req = r;
      step_cycle();
   endtask

   task automatic fill_line(logic [SET_W-1:0] set, int way, l2d_line_t line);
      l2d_req_t r;
      r = '0;
      r.way_sel    = NUM_WAYS'(1) << way;
      r.set        = set;
      r.col_offset = '1;
      r.word_en    = '1;
      r.stdecc     = '1;
      r.fill       = 1'b1;
      r.wr_line    = line;
      model_write(r, way);
      req = r;
      step_cycle();
   endtask

   task automatic send_read(logic [SET_W-1:0] set, int way, logic [NUM_SB-1:0] col,
                            logic fb, l2d_line_t fbl);
      l2d_req_t     r;
      l2d_line_t    src;
      l2d_line_t    masked;
      l2d_subline_t tag;
      r = '0;
      r.way_sel    = NUM_WAYS'(1) << way;
      r.rd_wr      = 1'b1;
      r.set        = set;
      r.col_offset = col;
      if (fb) begin
         src = fbl;
      end else begin
         src = model[loc_key(set, way)];
      end
      masked = '0;
      tag    = '0;
      for (int s = 0; s < NUM_SB; s++) begin
         if (col[s]) begin
            masked[s] = src[s];
            tag       = tag | src[s];
         end
      end
      exp_tag[cyc + TAG_LAT]   = tag;
      exp_line[cyc + LINE_LAT] = masked;
      if (fb) begin
         fb_hit_sched[cyc + 1]  = 1'b1;   // c3
         fb_line_sched[cyc + 2] = fbl;    // c4
      end
      req = r;
      step_cycle();
   endtask

   `include "l2d_bank_tests.svh"

   initial begin
      rst_n      = 1'b0;
      req        = '0;
      fb_hit     = 1'b0;
      fb_line    = '1;
      lfsr_state = LFSR_SEED;
      cyc        = 0;
      check_en   = 1'b0;
      for (int n = 0; n < 3; n++) begin
         step_cycle();
      end
      rst_n = 1'b1;
      reset_idle_check();
      store_then_tag_read();
      fill_then_evict();
      bypass_read();
      pipelined_reads();
      wait_drain();
      if (DUT.bank_checker.fail_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+dv
hdl/l2d_pkg.sv
hdl/l2d_req_stage.sv
hdl/l2d_subbank.sv
hdl/l2d_read_stage.sv
hdl/l2d_bank.sv
dv/l2d_bank_checker.sv
dv/l2d_bank_tb.sv

//--- run.sh
#!/bin/sh
# Build the l2d_bank testbench with Verilator and run it once.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f sources.f --top-module l2d_bank_tb \
   -Mdir obj_dir -o l2d_bank_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

# Keep running past a bound assertion so the testbench can report it
out=$(./obj_dir/l2d_bank_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1
